// File: garegga_map_pkg.sv
// main cpu memory map of the garegga board, region bases, ram sizes and address views
package garegga_map_pkg;

    // region bases as byte addresses
    localparam logic [23:0] PAL_BASE    = 24'h400000;  // palette ram
    localparam logic [23:0] TXVRAM_BASE = 24'h500000;  // text vram

    // page codes, compared by the decoder only
    localparam logic [7:0]  GP9001_PAGE = 8'h30;   // 0x300000, top byte
    localparam logic [11:0] IO_PAGE     = 12'h21C; // 0x21C000, 4k i/o page
    localparam logic [7:0]  SOUND_PAGE  = 8'h60;   // 0x600000, top byte

    // word address widths of the video rams
    localparam int PAL_AW    = 11;  // 0x400000 - 0x400FFF
    localparam int TXVRAM_AW = 12;  // 0x500000 - 0x501FFF

    // region view, top byte picks the device, low 16 bits inside it
    typedef struct packed {
        logic [7:0]  top;
        logic [15:0] ofs;
    } region_view_t;

    // i/o view, 4k pages as on the real board
    typedef struct packed {
        logic [11:0] page;
        logic [11:0] ofs;
    } io_view_t;

    // one byte address, read either way
    typedef union packed {
        region_view_t region;
        io_view_t     io;
    } bus_addr_t;

    // one-hot select, at most one member set per cycle
    typedef struct packed {
        logic pal;
        logic txvram;
        logic gp9001;
        logic io;
        logic sound;
    } dev_sel_t;

endpackage

// File: garegga_io_pkg.sv
// cabinet i/o offsets, game codes and video controller command codes
package garegga_io_pkg;

    // offsets inside the i/o page at 0x21C000
    localparam logic [11:0] IO_COINWORD = 12'h01C;  // coin counters, sample bank on kingdmgp
    localparam logic [11:0] IO_IN1      = 12'h020;  // player 1
    localparam logic [11:0] IO_IN2      = 12'h024;  // player 2
    localparam logic [11:0] IO_SYS      = 12'h028;  // coins, starts, test
    localparam logic [11:0] IO_DSWA     = 12'h02C;
    localparam logic [11:0] IO_DSWB     = 12'h030;
    localparam logic [11:0] IO_JMPR     = 12'h034;  // region jumpers
    localparam logic [11:0] IO_VCOUNT   = 12'h03C;  // video status

    // game codes
    localparam logic [7:0] GAME_GAREGGA  = 8'h00;
    localparam logic [7:0] GAME_SSTRIKER = 8'h01;
    localparam logic [7:0] GAME_KINGDMGP = 8'h02;

    // low address nibble of a video controller access
    localparam logic [3:0] GP_OFS_SET_PTR   = 4'h0;
    localparam logic [3:0] GP_OFS_RAM_H     = 4'h4;
    localparam logic [3:0] GP_OFS_RAM_L     = 4'h6;
    localparam logic [3:0] GP_OFS_SELECT    = 4'h8;
    localparam logic [3:0] GP_OFS_WRITE_REG = 4'hC;

    // video status bits, all active high in the word
    localparam int VS_HSYNC_BIT  = 15;
    localparam int VS_VSYNC_BIT  = 14;
    localparam int VS_FBLANK_BIT = 8;

    // command levels towards the video controller
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic set_ram_ptr;
    } gp_op_t;

endpackage

// File: cpu_bus_if.sv
// one registered main cpu bus cycle, from the decoder to the devices
interface cpu_bus_if import garegga_map_pkg::*; ();

    logic        cyc;    // one cycle strobe
    logic        we;
    bus_addr_t   addr;   // byte address
    logic [15:0] wdata;
    logic [1:0]  be;     // {upper, lower}
    dev_sel_t    sel;    // valid with cyc

    modport decoder (
        output cyc,
        output we,
        output addr,
        output wdata,
        output be,
        output sel
    );

    modport device (
        input cyc,
        input we,
        input addr,
        input wdata,
        input be,
        input sel
    );

endinterface

// File: video_ram_bank.sv
// dual port video ram, byte writes from the cpu side, read only video side
module video_ram_bank #(
    parameter int AW = 11
) (
    input  logic          clk96,
    cpu_bus_if.device     bus,
    input  logic          sel_me,
    output logic [15:0]   q,
    input  logic [AW-1:0] rd_addr,
    output logic [15:0]   rd_data
);

    logic [15:0]   mem [2**AW];
    logic [AW-1:0] cpu_addr;
    logic          hit;

    assign cpu_addr = bus.addr[AW:1];  // word address
    assign hit      = bus.cyc & sel_me;

    // cpu port
    always_ff @(posedge clk96) begin
        if (hit && bus.we && bus.be[1]) begin
            mem[cpu_addr][15:8] <= bus.wdata[15:8];
        end
        if (hit && bus.we && bus.be[0]) begin
            mem[cpu_addr][7:0] <= bus.wdata[7:0];
        end
        if (hit) begin
            q <= mem[cpu_addr];
        end
    end

    // video port
    always_ff @(posedge clk96) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: bus_decoder.sv
// bus decoder, registers each request, picks the device and returns read data
module bus_decoder import garegga_map_pkg::*; (
    input  logic        clk96,
    input  logic        reset96,
    input  logic        bus_req,
    input  logic        bus_we,
    input  logic        bus_uds,
    input  logic        bus_lds,
    input  logic [23:1] bus_addr,
    input  logic [15:0] bus_wdata,
    cpu_bus_if.decoder  bus,
    input  logic [15:0] pal_q,
    input  logic [15:0] txvram_q,
    input  logic [15:0] io_q,
    output logic        rd_valid,
    output logic [15:0] rd_data
);

    bus_addr_t req_addr;
    dev_sel_t  req_sel;
    dev_sel_t  rd_sel;   // device of the read now returning

    // true when the byte address falls in a ram of 2^aw words at base
    function automatic logic in_window(input logic [23:0] a, input logic [23:0] base,
                                       input int aw);
        in_window = (a >> (aw + 1)) == (base >> (aw + 1));
    endfunction

    assign req_addr = {bus_addr, 1'b0};  // byte address, easier to match the map

    always_comb begin
        req_sel        = '0;
        req_sel.pal    = in_window(req_addr, PAL_BASE, PAL_AW);
        req_sel.txvram = in_window(req_addr, TXVRAM_BASE, TXVRAM_AW);
        req_sel.gp9001 = req_addr.region.top == GP9001_PAGE;
        req_sel.io     = req_addr.io.page == IO_PAGE;     // 0x21C000 - 0x21CFFF
        req_sel.sound  = req_addr.region.top == SOUND_PAGE;
    end

    // strobe and select, cleared between requests
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus.cyc <= 1'b0;
            bus.sel <= '0;
        end else begin
            bus.cyc <= bus_req;
            bus.sel <= bus_req ? req_sel : '0;
        end
    end

    // request payload, only looked at while cyc is high
    always_ff @(posedge clk96) begin
        if (bus_req) begin
            bus.we    <= bus_we;
            bus.addr  <= req_addr;
            bus.wdata <= bus_wdata;
            bus.be    <= {bus_uds, bus_lds};
        end
    end

    // one stage of read tracking, devices answer one cycle after cyc
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            rd_valid <= 1'b0;
            rd_sel   <= '0;
        end else begin
            rd_valid <= bus.cyc & ~bus.we;  // unmapped reads answer too
            rd_sel   <= (bus.cyc & ~bus.we) ? bus.sel : '0;
        end
    end

    // and-or mux, zero when nothing selected
    assign rd_data = ({16{rd_sel.pal}}    & pal_q)
                   | ({16{rd_sel.txvram}} & txvram_q)
                   | ({16{rd_sel.io}}     & io_q);

endmodule

// File: cabinet_ports.sv
// cabinet inputs, dip switches and video status for reads of the i/o page
module cabinet_ports import garegga_io_pkg::*; (
    input  logic        clk96,
    input  logic        reset96,
    cpu_bus_if.device   bus,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [7:0]  dipsw_c,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        fblank,
    input  logic [8:0]  v,
    output logic [15:0] io_q
);

    logic [15:0] vstat;
    logic [7:0]  sys_lo;
    logic [15:0] word;

    // frame inputs are active high, the board wants active low
    // and direction bits in reverse order
    function automatic logic [7:0] player_byte(input logic [7:0] joy);
        player_byte = {1'b0, ~joy[6] | ~joy[7], ~joy[5] | ~joy[7], ~joy[4] | ~joy[7],
                       ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign sys_lo = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                     ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        vstat                = 16'hFF00;
        vstat[VS_HSYNC_BIT]  = hsync;   // low during sync
        vstat[VS_VSYNC_BIT]  = vsync;
        vstat[VS_FBLANK_BIT] = fblank;
        vstat[7:0]           = v[8] ? 8'hFF : v[7:0];  // saturates past line 255
    end

    always_comb begin
        case (bus.addr.io.ofs)
            IO_IN1:    word = {2{player_byte(joystick1)}};
            IO_IN2:    word = {2{player_byte(joystick2)}};
            IO_SYS:    word = {dipsw_c, sys_lo};
            IO_DSWA:   word = {2{dipsw_a}};
            IO_DSWB:   word = {2{dipsw_b}};
            IO_JMPR:   word = {2{dipsw_c}};
            IO_VCOUNT: word = vstat;
            default:   word = 16'h0000;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            io_q <= 16'h0000;
        end else if (bus.cyc && bus.sel.io && !bus.we) begin
            io_q <= word;
        end
    end

endmodule

// File: gp9001_cmd.sv
// video controller command levels and write data, held until acknowledge
module gp9001_cmd import garegga_io_pkg::*; (
    input  logic        clk96,
    input  logic        reset96,
    cpu_bus_if.device   bus,
    input  logic        gp_ack,
    output gp_op_t      gp_op,
    output logic [15:0] gp_data
);

    logic   wr;
    logic   known;   // offset maps to a command
    gp_op_t new_op;

    assign wr = bus.cyc & bus.sel.gp9001 & bus.we;

    always_comb begin
        new_op = '0;
        known  = 1'b1;
        case (bus.addr.region.ofs[3:0])
            GP_OFS_SET_PTR:   new_op.set_ram_ptr = 1'b1;
            GP_OFS_RAM_H,
            GP_OFS_RAM_L:     new_op.write_ram   = 1'b1;  // either half goes to ram
            GP_OFS_SELECT:    new_op.select_reg  = 1'b1;
            GP_OFS_WRITE_REG: new_op.write_reg   = 1'b1;
            default:          known              = 1'b0;
        endcase
    end

    // a new write wins over an ack in the same cycle
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            gp_op <= '0;
        end else if (wr && known) begin
            gp_op <= new_op;
        end else if (gp_ack) begin
            gp_op <= '0;
        end
    end

    always_ff @(posedge clk96) begin
        if (wr && known) begin
            gp_data <= bus.wdata;
        end
    end

endmodule

// File: sound_cmd.sv
// sound latch with sound cpu interrupt, and the sample bank register
module sound_cmd import garegga_io_pkg::*; (
    input  logic       clk96,
    input  logic       reset96,
    cpu_bus_if.device  bus,
    input  logic [7:0] game,
    output logic [7:0] sound_latch,
    output logic       z80_int,
    output logic [7:0] oki_bank
);

    logic latch_wr;
    logic bank_wr;

    assign latch_wr = bus.cyc & bus.sel.sound & bus.we;

    // only kingdmgp has a sample bank at the coin word
    assign bank_wr = bus.cyc & bus.sel.io & bus.we
                   & (bus.addr.io.ofs == IO_COINWORD)
                   & (game == GAME_KINGDMGP);

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sound_latch <= 8'h00;
            z80_int     <= 1'b0;
            oki_bank    <= 8'h00;
        end else begin
            z80_int <= latch_wr;  // one cycle per command
            if (latch_wr) begin
                sound_latch <= bus.wdata[7:0];
            end
            if (bank_wr) begin
                oki_bank <= bus.wdata[7:0];
            end
        end
    end

endmodule

// File: garegga_main_bus.sv
// main cpu bus side of the garegga board, decoder with video rams, i/o, video and sound ports
module garegga_main_bus import garegga_map_pkg::*, garegga_io_pkg::*; (
    input  logic                 clk96,
    input  logic                 reset96,
    // bus master
    input  logic                 bus_req,
    input  logic                 bus_we,
    input  logic                 bus_uds,
    input  logic                 bus_lds,
    input  logic [23:1]          bus_addr,
    input  logic [15:0]          bus_wdata,
    output logic                 rd_valid,
    output logic [15:0]          rd_data,
    // cabinet
    input  logic [7:0]           game,
    input  logic [7:0]           joystick1,
    input  logic [7:0]           joystick2,
    input  logic [1:0]           start_button,
    input  logic [1:0]           coin_input,
    input  logic                 service,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [7:0]           dipsw_c,
    // video timing
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 fblank,
    input  logic [8:0]           v,
    // video controller
    input  logic                 gp_ack,
    output gp_op_t               gp_op,
    output logic [15:0]          gp_data,
    // sound cpu
    output logic [7:0]           sound_latch,
    output logic                 z80_int,
    output logic [7:0]           oki_bank,
    // video side of the rams
    input  logic [PAL_AW-1:0]    pal_rd_addr,
    output logic [15:0]          pal_rd_data,
    input  logic [TXVRAM_AW-1:0] txvram_rd_addr,
    output logic [15:0]          txvram_rd_data
);

    logic [15:0] pal_q;
    logic [15:0] txvram_q;
    logic [15:0] io_q;

    cpu_bus_if bus ();

    bus_decoder u_decoder (
        .clk96     (clk96),
        .reset96   (reset96),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_uds   (bus_uds),
        .bus_lds   (bus_lds),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus       (bus.decoder),
        .pal_q     (pal_q),
        .txvram_q  (txvram_q),
        .io_q      (io_q),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    cabinet_ports u_cabinet (
        .clk96        (clk96),
        .reset96      (reset96),
        .bus          (bus.device),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .v            (v),
        .io_q         (io_q)
    );

    gp9001_cmd u_gp9001 (
        .clk96   (clk96),
        .reset96 (reset96),
        .bus     (bus.device),
        .gp_ack  (gp_ack),
        .gp_op   (gp_op),
        .gp_data (gp_data)
    );

    sound_cmd u_sound (
        .clk96       (clk96),
        .reset96     (reset96),
        .bus         (bus.device),
        .game        (game),
        .sound_latch (sound_latch),
        .z80_int     (z80_int),
        .oki_bank    (oki_bank)
    );

    video_ram_bank #(.AW(PAL_AW)) u_pal (
        .clk96   (clk96),
        .bus     (bus.device),
        .sel_me  (bus.sel.pal),
        .q       (pal_q),
        .rd_addr (pal_rd_addr),
        .rd_data (pal_rd_data)
    );

    video_ram_bank #(.AW(TXVRAM_AW)) u_txvram (
        .clk96   (clk96),
        .bus     (bus.device),
        .sel_me  (bus.sel.txvram),
        .q       (txvram_q),
        .rd_addr (txvram_rd_addr),
        .rd_data (txvram_rd_data)
    );

endmodule

// File: tb_garegga_main_bus.sv
// testbench for the main cpu bus block driven from a table of bus operations
module tb_garegga_main_bus import garegga_map_pkg::*, garegga_io_pkg::*;;

    localparam logic [3:0] OP_WR   = 4'd0;
    localparam logic [3:0] OP_RD   = 4'd1;
    localparam logic [3:0] OP_RD2  = 4'd2;  // two reads on consecutive cycles with d as 2nd word
    localparam logic [3:0] OP_RDP1 = 4'd3;  // player words expected from the joystick
    localparam logic [3:0] OP_RDP2 = 4'd4;
    localparam logic [3:0] OP_VID  = 4'd5;  // video port of either ram
    localparam logic [3:0] OP_GP   = 4'd6;
    localparam logic [3:0] OP_SND  = 4'd7;
    localparam logic [3:0] OP_BANK = 4'd8;
    localparam int TIMEOUT = 20;

    typedef struct packed {
        logic [3:0]  op;
        logic [23:0] a;      // byte address
        logic [15:0] d;
        logic [1:0]  be;     // {uds, lds}
        logic [15:0] exp;
        logic [2:0]  hvf;    // {hsync, vsync, fblank}
        logic [8:0]  line;
        logic [7:0]  code;   // game
    } entry_t;

    logic clk96 = 1'b0;
    logic reset96;
    logic bus_req, bus_we, bus_uds, bus_lds;
    logic [23:1] bus_addr;
    logic [15:0] bus_wdata, rd_data, gp_data, pal_rd_data, txvram_rd_data;
    logic rd_valid, service, dip_test, hsync, vsync, fblank, gp_ack, z80_int;
    logic [7:0] game, joystick1, joystick2, dipsw_a, dipsw_b, dipsw_c, sound_latch, oki_bank;
    logic [1:0] start_button, coin_input;
    logic [8:0] v;
    gp_op_t gp_op;
    logic [PAL_AW-1:0] pal_rd_addr;
    logic [TXVRAM_AW-1:0] txvram_rd_addr;

    entry_t tbl [64];
    entry_t e;
    int n_tbl = 0;
    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cur = 0;
    int start_err;

    garegga_main_bus uut (.*);

    always #4 clk96 = ~clk96;

    function automatic void append_row(input logic [3:0] op, input logic [23:0] a,
                                       input logic [15:0] d, input logic [1:0] be,
                                       input logic [15:0] exp, input logic [2:0] hvf,
                                       input logic [8:0] line, input logic [7:0] code);
        tbl[n_tbl] = {op, a, d, be, exp, hvf, line, code};
        n_tbl++;
    endfunction

    function automatic void bus_row(input logic [3:0] op, input logic [23:0] a,
                                    input logic [15:0] d, input logic [1:0] be,
                                    input logic [15:0] exp);
        append_row(op, a, d, be, exp, 3'b111, 9'd0, GAME_GAREGGA);
    endfunction

    // active low player byte with reversed directions
    function automatic logic [15:0] player_word(input logic [7:0] j);
        logic [7:0] b;
        b[7] = 1'b0;
        for (int i = 4; i < 7; i++) begin
            b[i] = !(j[i] && j[7]);
        end
        for (int i = 0; i < 4; i++) begin
            b[i] = !j[3 - i];
        end
        return {b, b};
    endfunction

    task automatic report_mismatch(input string what, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("mismatch at %0t: test %0d %s is %h, expected %h", $time, cur, what, got, exp);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("test %0d at %0t: %s", cur, $time, msg);
        errors++;
    endtask

    task automatic tick();
        @(posedge clk96);
        #1;
    endtask

    // one cycle request that returns one cycle after it
    task automatic issue(input logic we, input logic [23:0] a, input logic [15:0] d,
                         input logic [1:0] be);
        bus_req            = 1'b1;
        bus_we             = we;
        bus_addr           = a[23:1];
        bus_wdata          = d;
        {bus_uds, bus_lds} = be;
        tick();
        bus_req = 1'b0;
    endtask

    task automatic read_word(input logic [23:0] a, input logic [15:0] exp);
        int n;
        issue(1'b0, a, 16'h0000, 2'b11);
        n = 0;
        while (!rd_valid && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!rd_valid) begin
            note_failure("no rd_valid after a read request");
        end else begin
            if (n != 1) note_failure("rd_valid not two cycles after the request");
            if (rd_data !== exp) report_mismatch("rd_data", rd_data, exp);
        end
    endtask

    // each answer exactly two cycles after its request
    task automatic read_pair(input logic [23:0] a, input logic [15:0] exp0,
                             input logic [15:0] exp1);
        issue(1'b0, a, 16'h0000, 2'b11);
        issue(1'b0, a + 24'd2, 16'h0000, 2'b11);
        if (!rd_valid) note_failure("first rd_valid missing");
        if (rd_data !== exp0) report_mismatch("first rd_data", rd_data, exp0);
        tick();
        if (!rd_valid) note_failure("second rd_valid missing");
        if (rd_data !== exp1) report_mismatch("second rd_data", rd_data, exp1);
        tick();
        if (rd_valid) note_failure("rd_valid stayed high after two reads");
    endtask

    task automatic video_read(input logic [23:0] a, input logic [15:0] exp);
        tick();  // let the last write land
        if (a[23:20] == 4'h5) begin
            txvram_rd_addr = a[TXVRAM_AW:1];
            tick();
            if (txvram_rd_data !== exp) begin
                report_mismatch("txvram_rd_data", txvram_rd_data, exp);
            end
        end else begin
            pal_rd_addr = a[PAL_AW:1];
            tick();
            if (pal_rd_data !== exp) report_mismatch("pal_rd_data", pal_rd_data, exp);
        end
    endtask

    task automatic gp_command(input logic [23:0] a, input logic [15:0] d, input logic [3:0] exp);
        int n;
        issue(1'b1, a, d, 2'b11);
        n = 0;
        while (gp_op == 4'h0 && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (gp_op == 4'h0) begin
            note_failure("no command level after the write");
        end else begin
            if (gp_op !== exp) report_mismatch("gp_op", {12'h000, gp_op}, {12'h000, exp});
            if (gp_data !== d) report_mismatch("gp_data", gp_data, d);
            repeat (3) begin
                tick();
                if (gp_op !== exp) note_failure("command level dropped before gp_ack");
            end
            gp_ack = 1'b1;
            tick();
            gp_ack = 1'b0;
            n = 0;
            while (gp_op !== 4'h0 && n < TIMEOUT) begin
                tick();
                n++;
            end
            if (gp_op !== 4'h0) note_failure("command level still high after gp_ack");
        end
    endtask

    task automatic sound_write(input logic [23:0] a, input logic [15:0] d, input logic [7:0] exp);
        int n;
        int pulses;
        issue(1'b1, a, d, 2'b11);
        n = 0;
        while (!z80_int && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!z80_int) begin
            note_failure("no z80_int after a sound write");
        end else begin
            pulses = 1;
            if (sound_latch !== exp) begin
                report_mismatch("sound_latch", {8'h00, sound_latch}, {8'h00, exp});
            end
            repeat (4) begin
                tick();
                if (z80_int) pulses++;
            end
            if (pulses != 1) note_failure("z80_int was not a single pulse");
        end
    endtask

    task automatic bank_write(input logic [23:0] a, input logic [15:0] d, input logic [7:0] exp);
        issue(1'b1, a, d, 2'b11);
        tick();
        tick();
        if (oki_bank !== exp) report_mismatch("oki_bank", {8'h00, oki_bank}, {8'h00, exp});
    endtask

    function automatic void fill_table();
        // palette word then byte writes
        bus_row(OP_WR,   24'h400010, 16'h1234, 2'b11, 16'h0000);
        bus_row(OP_WR,   24'h400010, 16'hAB00, 2'b10, 16'h0000);
        bus_row(OP_RD,   24'h400010, 16'h0000, 2'b11, 16'hAB34);
        bus_row(OP_WR,   24'h400010, 16'h00CD, 2'b01, 16'h0000);
        bus_row(OP_RD,   24'h400010, 16'h0000, 2'b11, 16'hABCD);
        bus_row(OP_VID,  24'h400010, 16'h0000, 2'b11, 16'hABCD);
        bus_row(OP_WR,   24'h400FFE, 16'hBEEF, 2'b11, 16'h0000);
        bus_row(OP_RD,   24'h400FFE, 16'h0000, 2'b11, 16'hBEEF);
        bus_row(OP_VID,  24'h400FFE, 16'h0000, 2'b11, 16'hBEEF);
        // text vram writes run back to back
        bus_row(OP_WR,   24'h500000, 16'h1111, 2'b11, 16'h0000);
        bus_row(OP_WR,   24'h500002, 16'h2222, 2'b11, 16'h0000);
        bus_row(OP_WR,   24'h501FFE, 16'h3333, 2'b11, 16'h0000);
        bus_row(OP_RD2,  24'h500000, 16'h2222, 2'b11, 16'h1111);
        bus_row(OP_RD,   24'h501FFE, 16'h0000, 2'b11, 16'h3333);
        bus_row(OP_VID,  24'h500002, 16'h0000, 2'b11, 16'h2222);
        bus_row(OP_VID,  24'h501FFE, 16'h0000, 2'b11, 16'h3333);
        bus_row(OP_RD,   24'h502000, 16'h0000, 2'b11, 16'h0000);  // past the window
        bus_row(OP_RD,   24'h700000, 16'h0000, 2'b11, 16'h0000);
        // cabinet words
        for (int i = 0; i < 3; i++) begin
            bus_row(OP_RDP1, 24'h21C020, 16'h0000, 2'b11, 16'h0000);
            bus_row(OP_RDP2, 24'h21C024, 16'h0000, 2'b11, 16'h0000);
        end
        bus_row(OP_RD,   24'h21C028, 16'h0000, 2'b11, 16'h814C);
        bus_row(OP_RD,   24'h21C02C, 16'h0000, 2'b11, 16'h5A5A);
        bus_row(OP_RD,   24'h21C030, 16'h0000, 2'b11, 16'hC3C3);
        bus_row(OP_RD,   24'h21C034, 16'h0000, 2'b11, 16'h8181);
        bus_row(OP_RD,   24'h21C038, 16'h0000, 2'b11, 16'h0000);
        // video status
        append_row(OP_RD, 24'h21C03C, 16'h0000, 2'b11, 16'h7F64, 3'b011, 9'd100, GAME_GAREGGA);
        append_row(OP_RD, 24'h21C03C, 16'h0000, 2'b11, 16'hBF64, 3'b101, 9'd100, GAME_GAREGGA);
        append_row(OP_RD, 24'h21C03C, 16'h0000, 2'b11, 16'hFE64, 3'b110, 9'd100, GAME_GAREGGA);
        append_row(OP_RD, 24'h21C03C, 16'h0000, 2'b11, 16'hFF64, 3'b111, 9'd100, GAME_GAREGGA);
        append_row(OP_RD, 24'h21C03C, 16'h0000, 2'b11, 16'hFFFF, 3'b111, 9'd300, GAME_GAREGGA);
        append_row(OP_RD, 24'h21C03C, 16'h0000, 2'b11, 16'h7EFF, 3'b010, 9'd300, GAME_GAREGGA);
        // exp holds the video controller op level
        bus_row(OP_GP,   24'h300000, 16'h0101, 2'b11, 16'h0001);
        bus_row(OP_GP,   24'h300004, 16'h0202, 2'b11, 16'h0002);
        bus_row(OP_GP,   24'h300006, 16'h0606, 2'b11, 16'h0002);
        bus_row(OP_GP,   24'h300008, 16'h0303, 2'b11, 16'h0008);
        bus_row(OP_GP,   24'h30000C, 16'h0404, 2'b11, 16'h0004);
        // sound latch and sample bank
        bus_row(OP_SND,  24'h600000, 16'h00A5, 2'b11, 16'h00A5);
        bus_row(OP_SND,  24'h600000, 16'h123C, 2'b11, 16'h003C);
        append_row(OP_BANK, 24'h21C01C, 16'h0033, 2'b11, 16'h0000, 3'b111, 9'd0, GAME_GAREGGA);
        append_row(OP_BANK, 24'h21C01C, 16'h0033, 2'b11, 16'h0033, 3'b111, 9'd0, GAME_KINGDMGP);
        append_row(OP_BANK, 24'h21C01C, 16'h0077, 2'b11, 16'h0033, 3'b111, 9'd0, GAME_SSTRIKER);
    endfunction

    initial begin
        void'($urandom(22));
        reset96 = 1'b1;
        bus_req = 1'b0;
        bus_we = 1'b0;
        bus_uds = 1'b0;
        bus_lds = 1'b0;
        bus_addr = '0;
        bus_wdata = 16'h0000;
        game = GAME_GAREGGA;
        joystick1 = 8'h00;
        joystick2 = 8'h00;
        start_button = 2'b01;  // sys low byte comes out as 4C
        coin_input = 2'b10;
        service = 1'b1;
        dip_test = 1'b0;
        dipsw_a = 8'h5A;
        dipsw_b = 8'hC3;
        dipsw_c = 8'h81;
        {hsync, vsync, fblank} = 3'b111;
        v = 9'd0;
        gp_ack = 1'b0;
        pal_rd_addr = '0;
        txvram_rd_addr = '0;
        fill_table();

        repeat (2) @(posedge clk96);
        #1;
        reset96 = 1'b0;

        if (rd_valid !== 1'b0 || z80_int !== 1'b0 || gp_op !== 4'h0
            || sound_latch !== 8'h00 || oki_bank !== 8'h00 || rd_data !== 16'h0000) begin
            note_failure("outputs not cleared by reset");
            failed++;
            $display("reset check: fail");
        end else begin
            passed++;
            $display("reset check: pass");
        end

        for (int i = 0; i < n_tbl; i++) begin
            e = tbl[i];
            cur = i;
            start_err = errors;
            joystick1 = 8'($urandom);
            joystick2 = 8'($urandom);
            {hsync, vsync, fblank} = e.hvf;
            v = e.line;
            game = e.code;
            case (e.op)
                OP_WR:   issue(1'b1, e.a, e.d, e.be);
                OP_RD:   read_word(e.a, e.exp);
                OP_RD2:  read_pair(e.a, e.exp, e.d);
                OP_RDP1: read_word(e.a, player_word(joystick1));
                OP_RDP2: read_word(e.a, player_word(joystick2));
                OP_VID:  video_read(e.a, e.exp);
                OP_GP:   gp_command(e.a, e.d, e.exp[3:0]);
                OP_SND:  sound_write(e.a, e.d, e.exp[7:0]);
                OP_BANK: bank_write(e.a, e.d, e.exp[7:0]);
                default: note_failure("unknown table op");
            endcase
            if (errors == start_err) begin
                passed++;
                $display("test %0d op %0d addr %h: pass", i, e.op, e.a);
            end else begin
                failed++;
                $display("test %0d op %0d addr %h: fail", i, e.op, e.a);
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
garegga_map_pkg.sv
garegga_io_pkg.sv
cpu_bus_if.sv
video_ram_bank.sv
bus_decoder.sv
cabinet_ports.sv
gp9001_cmd.sv
sound_cmd.sv
garegga_main_bus.sv
tb_garegga_main_bus.sv

// File: Bender.yml
package:
  name: garegga_main_bus

sources:
  - files:
      - garegga_map_pkg.sv
      - garegga_io_pkg.sv
      - cpu_bus_if.sv
      - video_ram_bank.sv
      - bus_decoder.sv
      - cabinet_ports.sv
      - gp9001_cmd.sv
      - sound_cmd.sv
      - garegga_main_bus.sv
  - target: simulation
    files:
      - tb_garegga_main_bus.sv
